// File: src/buf_data_pkg.sv
`default_nettype none

// Data path types seen by steering, FIFOs and egress
package buf_data_pkg;

	// One FIFO per traffic class
	localparam int NUM_CLASSES = 4;

	// Width of the data byte carried in every word
	localparam int PAYLOAD_W = 8;

	// Class tag
	// CLS_0 is served first after reset
	typedef enum logic [1:0] {
		CLS_0 = 2'd0,
		CLS_1 = 2'd1,
		CLS_2 = 2'd2,
		CLS_3 = 2'd3
	} class_e;

	// Tagged word with the class in the upper two bits
	typedef struct packed {
		class_e                 cls;
		logic [PAYLOAD_W-1:0]   payload;
	} word_t;

endpackage

`default_nettype wire

// File: src/buf_cfg_pkg.sv
`default_nettype none

// Register map and configuration types for the APB block
package buf_cfg_pkg;

	// Width of one per-class fill level in REG_FILL
	localparam int FILL_W = 8;

	// Egress enable position in REG_CTRL
	localparam int CTRL_EN_BIT = 0;

	// Register offsets, word aligned
	typedef enum logic [3:0] {
		REG_CTRL   = 4'h0,
		REG_THRESH = 4'h4,
		REG_STATUS = 4'h8,
		REG_FILL   = 4'hC
	} reg_addr_e;

	// Threshold levels as laid out in REG_THRESH
	// almost_full in bits 15:8, almost_empty in bits 7:0
	typedef struct packed {
		logic [7:0] almost_full;
		logic [7:0] almost_empty;
	} thresh_t;

	// Levels after reset
	localparam thresh_t THRESH_RESET = '{
		almost_full:  8'd3,
		almost_empty: 8'd1
	};

endpackage

`default_nettype wire

// File: src/flow_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module flow_fifo #(
	parameter int DEPTH  = 4,
	parameter int DATA_W = 8
) (
	input  wire                             clk,
	input  wire                             reset_L,
	input  wire                             i_wr,
	input  wire  [DATA_W-1:0]               i_wr_data,
	input  wire                             i_rd,
	input  wire  buf_cfg_pkg::thresh_t      i_thresh,
	output logic [DATA_W-1:0]               o_rd_data,
	output logic                            o_full,
	output logic                            o_empty,
	output logic                            o_almost_full,
	output logic                            o_almost_empty,
	output logic [buf_cfg_pkg::FILL_W-1:0]  o_fill,
	output logic                            o_overrun
);

	localparam int FW = buf_cfg_pkg::FILL_W;
	localparam int PTR_W = $clog2(DEPTH);
	// Pointer value where it wraps back to zero
	localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);
	// Counter value when every entry holds data
	localparam logic [FW-1:0] FULL_LVL = FW'(DEPTH);

	// Storage
	logic [DATA_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic wr_ok;
	logic rd_ok;

	// Pop only with data present
	assign rd_ok = i_rd && !o_empty;
	// Full FIFO still takes a write when the head leaves in the same cycle
	assign wr_ok = i_wr && (!o_full || rd_ok);

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= i_wr_data;
		end
	end

	// First word fall through
	// head entry is on the output whenever the FIFO is not empty
	assign o_rd_data = mem[rd_ptr];

	// Write pointer wraps at DEPTH, which need not be a power of two
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			wr_ptr <= '0;
		end else if (wr_ok) begin
			wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
		end
	end

	// Read pointer
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			rd_ptr <= '0;
		end else if (rd_ok) begin
			rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
		end
	end

	// Fill counter
	// Simultaneous write and read leaves it unchanged
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			o_fill <= '0;
		end else begin
			case ({wr_ok, rd_ok})
				2'b10:   o_fill <= o_fill + 1'b1;
				2'b01:   o_fill <= o_fill - 1'b1;
				default: o_fill <= o_fill;
			endcase
		end
	end

	// Dropped write gives a one cycle pulse
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			o_overrun <= 1'b0;
		end else begin
			o_overrun <= i_wr && !wr_ok;
		end
	end

	// Flags decoded from the counter
	assign o_full = (o_fill == FULL_LVL);
	assign o_empty = (o_fill == '0);
	// Almost levels come from REG_THRESH
	assign o_almost_full = (o_fill >= i_thresh.almost_full);
	assign o_almost_empty = (o_fill <= i_thresh.almost_empty);

	// Counter must never run past the storage
	a_fill_bound: assert property (@(posedge clk) disable iff (!reset_L)
		o_fill <= FULL_LVL)
		else $error("flow_fifo fill above DEPTH");

	// Arbiter only pops FIFOs it saw as non-empty
	a_no_empty_rd: assert property (@(posedge clk) disable iff (!reset_L)
		i_rd |-> !o_empty)
		else $error("flow_fifo read while empty");

endmodule

`default_nettype wire

// File: src/class_steer.sv
`timescale 1ns/100ps
`default_nettype none

module class_steer #(
	parameter int DATA_W = 8
) (
	input  wire                                 i_in_valid,
	input  wire  buf_data_pkg::word_t           i_in_word,
	output logic [buf_data_pkg::NUM_CLASSES-1:0] o_wr,
	output logic [DATA_W-1:0]                   o_payload
);

	localparam int NC = buf_data_pkg::NUM_CLASSES;

	// One write strobe per class FIFO
	// Class tag selects the bit, valid gates the whole vector
	always_comb begin
		o_wr = '0;
		if (i_in_valid) begin
			o_wr = NC'(1) << i_in_word.cls;
		end
	end

	// Tag is carried by the strobe, only the byte goes to the FIFOs
	assign o_payload = i_in_word.payload;

	// A valid word needs a known tag or no FIFO gets a clean strobe
	always_comb begin
		if (i_in_valid) begin
			a_tag_known: assert (!$isunknown(i_in_word.cls))
				else $error("class_steer got a valid word with an unknown class");
		end
	end

endmodule

`default_nettype wire

// File: src/egress_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module egress_arbiter #(
	parameter int DATA_W = 8
) (
	input  wire                                             clk,
	input  wire                                             reset_L,
	input  wire                                             i_enable,
	input  wire  [buf_data_pkg::NUM_CLASSES-1:0]             i_empty,
	input  wire  [buf_data_pkg::NUM_CLASSES-1:0][DATA_W-1:0] i_head,
	input  wire                                             i_out_ready,
	output logic [buf_data_pkg::NUM_CLASSES-1:0]             o_rd,
	output logic                                            o_out_valid,
	output buf_data_pkg::word_t                             o_out_word
);

	localparam int NC = buf_data_pkg::NUM_CLASSES;

	// Class granted last
	// Reset value makes CLS_0 the first candidate
	buf_data_pkg::class_e last_grant;
	buf_data_pkg::class_e sel;
	logic [1:0] cand;
	logic found;
	logic take;

	// Round robin search
	// Walks from the farthest class to the nearest one after last_grant
	// The last hit wins, so the nearest non-empty class is chosen
	always_comb begin
		sel = last_grant;
		found = 1'b0;
		cand = '0;
		for (int off = NC; off >= 1; off--) begin
			cand = last_grant + 2'(off);
			if (!i_empty[cand]) begin
				sel = buf_data_pkg::class_e'(cand);
				found = 1'b1;
			end
		end
	end

	// Load when the output stage is free or handing off this cycle
	assign take = i_enable && found && (!o_out_valid || i_out_ready);

	// Pop strobe to the chosen FIFO
	assign o_rd = take ? (NC'(1) << sel) : '0;

	// Output valid and pointer state
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			o_out_valid <= 1'b0;
			last_grant <= buf_data_pkg::CLS_3;
		end else if (take) begin
			o_out_valid <= 1'b1;
			last_grant <= sel;
		end else if (i_out_ready) begin
			o_out_valid <= 1'b0;
		end
	end

	// Output word register
	// head byte tagged with the class it came from
	always_ff @(posedge clk) begin
		if (take) begin
			o_out_word.cls <= sel;
			o_out_word.payload <= i_head[sel];
		end
	end

	// Stalled output holds until the sink takes it
	a_out_hold: assert property (@(posedge clk) disable iff (!reset_L)
		o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_word))
		else $error("egress word changed under back-pressure");

endmodule

`default_nettype wire

// File: src/buf_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module buf_apb_regs (
	input  wire                                                        clk,
	input  wire                                                        reset_L,
	input  wire                                                        i_psel,
	input  wire                                                        i_penable,
	input  wire                                                        i_pwrite,
	input  wire  [3:0]                                                 i_paddr,
	input  wire  [31:0]                                                i_pwdata,
	input  wire  [buf_data_pkg::NUM_CLASSES-1:0]                        i_overrun,
	input  wire  [buf_data_pkg::NUM_CLASSES-1:0][buf_cfg_pkg::FILL_W-1:0] i_fill,
	output logic [31:0]                                                o_prdata,
	output logic                                                       o_enable,
	output buf_cfg_pkg::thresh_t                                       o_thresh
);

	localparam int NC = buf_data_pkg::NUM_CLASSES;
	localparam int TW = $bits(buf_cfg_pkg::thresh_t);

	buf_cfg_pkg::reg_addr_e addr;
	logic wr_access;
	// Sticky overrun flags, one per class
	logic [NC-1:0] status;
	logic [NC-1:0] clr;

	assign addr = buf_cfg_pkg::reg_addr_e'(i_paddr);
	// Writes land at the access edge
	assign wr_access = i_psel && i_penable && i_pwrite;

	// CTRL and THRESH
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			o_enable <= 1'b0;
			o_thresh <= buf_cfg_pkg::THRESH_RESET;
		end else if (wr_access) begin
			case (addr)
				buf_cfg_pkg::REG_CTRL: begin
					o_enable <= i_pwdata[buf_cfg_pkg::CTRL_EN_BIT];
				end
				buf_cfg_pkg::REG_THRESH: begin
					o_thresh <= buf_cfg_pkg::thresh_t'(i_pwdata[TW-1:0]);
				end
				default: begin
				end
			endcase
		end
	end

	// Write 1 to clear
	assign clr = (wr_access && addr == buf_cfg_pkg::REG_STATUS) ? i_pwdata[NC-1:0] : '0;

	// New overrun pulse wins over a clear in the same cycle
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			status <= '0;
		end else begin
			status <= (status & ~clr) | i_overrun;
		end
	end

	// Read mux
	// unmapped offsets read zero
	always_comb begin
		o_prdata = '0;
		case (addr)
			buf_cfg_pkg::REG_CTRL:   o_prdata[buf_cfg_pkg::CTRL_EN_BIT] = o_enable;
			buf_cfg_pkg::REG_THRESH: o_prdata = 32'(o_thresh);
			buf_cfg_pkg::REG_STATUS: o_prdata = 32'(status);
			// Class 0 in the low byte
			buf_cfg_pkg::REG_FILL:   o_prdata = 32'(i_fill);
			default:                 o_prdata = '0;
		endcase
	end

	// Access phase must follow a setup cycle with the same select
	a_apb_phase: assert property (@(posedge clk) disable iff (!reset_L)
		i_penable |-> i_psel && $past(i_psel && !i_penable))
		else $error("APB access phase without setup");

endmodule

`default_nettype wire

// File: src/class_buffer_top.sv
`timescale 1ns/100ps
`default_nettype none

module class_buffer_top #(
	parameter int DEPTH  = 4,
	parameter int DATA_W = 8
) (
	input  wire                                  clk,
	input  wire                                  reset_L,
	input  wire                                  i_in_valid,
	input  wire  buf_data_pkg::word_t            i_in_word,
	input  wire                                  i_out_ready,
	input  wire                                  i_psel,
	input  wire                                  i_penable,
	input  wire                                  i_pwrite,
	input  wire  [3:0]                           i_paddr,
	input  wire  [31:0]                          i_pwdata,
	output logic                                 o_out_valid,
	output buf_data_pkg::word_t                  o_out_word,
	output logic [31:0]                          o_prdata,
	output logic [buf_data_pkg::NUM_CLASSES-1:0] o_almost_full
);

	localparam int NC = buf_data_pkg::NUM_CLASSES;
	localparam int FW = buf_cfg_pkg::FILL_W;

	// Ingress to FIFOs
	logic [NC-1:0] wr;
	logic [DATA_W-1:0] payload;
	// FIFOs to arbiter
	logic [NC-1:0] empty;
	logic [NC-1:0][DATA_W-1:0] head;
	logic [NC-1:0] rd;
	// Status and config
	logic [NC-1:0][FW-1:0] fill;
	logic [NC-1:0] overrun;
	logic enable;
	buf_cfg_pkg::thresh_t thresh;

	class_steer #(.DATA_W(DATA_W)) u_steer (
		.i_in_valid (i_in_valid),
		.i_in_word  (i_in_word),
		.o_wr       (wr),
		.o_payload  (payload)
	);

	// One FIFO per class
	// full and almost_empty are not used at this level
	for (genvar c = 0; c < NC; c++) begin : g_fifo
		flow_fifo #(.DEPTH(DEPTH), .DATA_W(DATA_W)) u_fifo (
			.clk            (clk),
			.reset_L        (reset_L),
			.i_wr           (wr[c]),
			.i_wr_data      (payload),
			.i_rd           (rd[c]),
			.i_thresh       (thresh),
			.o_rd_data      (head[c]),
			.o_full         (),
			.o_empty        (empty[c]),
			.o_almost_full  (o_almost_full[c]),
			.o_almost_empty (),
			.o_fill         (fill[c]),
			.o_overrun      (overrun[c])
		);
	end

	egress_arbiter #(.DATA_W(DATA_W)) u_arb (
		.clk         (clk),
		.reset_L     (reset_L),
		.i_enable    (enable),
		.i_empty     (empty),
		.i_head      (head),
		.i_out_ready (i_out_ready),
		.o_rd        (rd),
		.o_out_valid (o_out_valid),
		.o_out_word  (o_out_word)
	);

	buf_apb_regs u_regs (
		.clk       (clk),
		.reset_L   (reset_L),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.i_overrun (overrun),
		.i_fill    (fill),
		.o_prdata  (o_prdata),
		.o_enable  (enable),
		.o_thresh  (thresh)
	);

	// Payload width must agree with the tagged word layout
	a_data_w: assert property (@(posedge clk) DATA_W == buf_data_pkg::PAYLOAD_W)
		else $error("DATA_W differs from the package payload width");

endmodule

`default_nettype wire

// File: sim/tb_class_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_class_buffer;

	localparam int DEPTH = 4;
	localparam int DATA_W = 8;
	localparam int NC = buf_data_pkg::NUM_CLASSES;
	localparam int CLK_PERIOD = 40;
	// Cycles any single wait may take
	localparam int TIMEOUT = 200;

	logic clk;
	logic reset_L;
	logic i_in_valid;
	buf_data_pkg::word_t i_in_word;
	logic i_out_ready;
	logic i_psel;
	logic i_penable;
	logic i_pwrite;
	logic [3:0] i_paddr;
	logic [31:0] i_pwdata;
	logic o_out_valid;
	buf_data_pkg::word_t o_out_word;
	logic [31:0] o_prdata;
	logic [NC-1:0] o_almost_full;

	// Reference model, one queue and one fill count per class
	buf_data_pkg::word_t model_q[NC][$];
	int fill_cnt[NC];
	buf_cfg_pkg::thresh_t cur_thresh;
	integer seed;
	int err_cnt;
	int chk_cnt;
	int test_start;

	class_buffer_top #(.DEPTH(DEPTH), .DATA_W(DATA_W)) u_dut (
		.clk           (clk),
		.reset_L       (reset_L),
		.i_in_valid    (i_in_valid),
		.i_in_word     (i_in_word),
		.i_out_ready   (i_out_ready),
		.i_psel        (i_psel),
		.i_penable     (i_penable),
		.i_pwrite      (i_pwrite),
		.i_paddr       (i_paddr),
		.i_pwdata      (i_pwdata),
		.o_out_valid   (o_out_valid),
		.o_out_word    (o_out_word),
		.o_prdata      (o_prdata),
		.o_almost_full (o_almost_full)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_word(input buf_data_pkg::word_t got, input buf_data_pkg::word_t exp,
			input string what);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERROR %0t: %s got class %0d data %h, expected class %0d data %h",
				$time, what, got.cls, got.payload, exp.cls, exp.payload);
		end
	endtask

	task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERROR %0t: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_thresh(input buf_cfg_pkg::thresh_t got,
			input buf_cfg_pkg::thresh_t exp, input string what);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERROR %0t: %s got full %0d empty %0d, expected full %0d empty %0d",
				$time, what, got.almost_full, got.almost_empty,
				exp.almost_full, exp.almost_empty);
		end
	endtask

	task automatic abort_run(input string what);
		$display("Simulation stopped, timed out waiting for %s at %0t", what, $time);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic finish_test(input string name);
		$display("Test %-16s finished with %0d errors", name, err_cnt - test_start);
	endtask

	// APB write, setup then access, done at the access edge
	task automatic apb_write(input buf_cfg_pkg::reg_addr_e addr, input logic [31:0] data);
		@(posedge clk);
		i_psel <= 1'b1;
		i_penable <= 1'b0;
		i_pwrite <= 1'b1;
		i_paddr <= addr;
		i_pwdata <= data;
		@(posedge clk);
		i_penable <= 1'b1;
		@(posedge clk);
		i_psel <= 1'b0;
		i_penable <= 1'b0;
		i_pwrite <= 1'b0;
	endtask

	// Read data sampled mid access phase
	task automatic apb_read(input buf_cfg_pkg::reg_addr_e addr, output logic [31:0] data);
		@(posedge clk);
		i_psel <= 1'b1;
		i_penable <= 1'b0;
		i_pwrite <= 1'b0;
		i_paddr <= addr;
		@(posedge clk);
		i_penable <= 1'b1;
		@(negedge clk);
		data = o_prdata;
		@(posedge clk);
		i_psel <= 1'b0;
		i_penable <= 1'b0;
	endtask

	// One word, valid for a single cycle, accepted at the second edge
	task automatic send_word(input buf_data_pkg::word_t w);
		@(posedge clk);
		i_in_valid <= 1'b1;
		i_in_word <= w;
		@(posedge clk);
		i_in_valid <= 1'b0;
	endtask

	// Upstream flow control on the per class almost full output
	task automatic wait_room(input buf_data_pkg::class_e cls);
		int waited;
		waited = 0;
		@(negedge clk);
		while (o_almost_full[cls] && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (o_almost_full[cls]) begin
			abort_run("almost_full to drop");
		end
	endtask

	// Waits for one transfer, matches it against the queue of its class
	// Stalled cycles also check that valid and the word hold
	task automatic expect_word(input bit random_ready);
		int waited;
		bit got;
		bit stalled;
		integer rnd;
		buf_data_pkg::word_t held;
		buf_data_pkg::word_t seen;
		buf_data_pkg::word_t exp;
		waited = 0;
		got = 1'b0;
		stalled = 1'b0;
		while (!got && waited < TIMEOUT) begin
			@(posedge clk);
			rnd = $random(seed);
			i_out_ready <= random_ready ? rnd[0] : 1'b1;
			@(negedge clk);
			if (stalled) begin
				check_reg(32'(o_out_valid), 32'd1, "valid under back-pressure");
				check_word(o_out_word, held, "word under back-pressure");
			end
			stalled = o_out_valid && !i_out_ready;
			held = o_out_word;
			if (o_out_valid && i_out_ready) begin
				seen = o_out_word;
				got = 1'b1;
			end
			waited++;
		end
		if (!got) begin
			abort_run("an egress transfer");
		end else if (model_q[seen.cls].size() == 0) begin
			err_cnt++;
			$display("Unexpected word of class %0d data %h left the buffer at %0t",
				seen.cls, seen.payload, $time);
		end else begin
			exp = model_q[seen.cls].pop_front();
			check_word(seen, exp, "egress word");
		end
	endtask

	// Expected almost full vector from the model fill counts
	function automatic logic [NC-1:0] afull_vector();
		logic [NC-1:0] v;
		for (int c = 0; c < NC; c++) begin
			v[c] = fill_cnt[c] >= 32'(cur_thresh.almost_full);
		end
		return v;
	endfunction

	// REG_FILL layout with class 0 in the low byte
	function automatic logic [31:0] fill_word();
		logic [31:0] v;
		for (int c = 0; c < NC; c++) begin
			v[c*8 +: 8] = fill_cnt[c][7:0];
		end
		return v;
	endfunction

	task automatic feed_words(input int n, input bit mixed);
		integer rnd;
		buf_data_pkg::word_t w;
		for (int i = 0; i < n; i++) begin
			rnd = $random(seed);
			w.cls = mixed ? buf_data_pkg::class_e'(rnd[9:8]) : buf_data_pkg::CLS_2;
			w.payload = rnd[7:0];
			wait_room(w.cls);
			model_q[w.cls].push_back(w);
			send_word(w);
		end
	endtask

	task automatic check_idle();
		@(negedge clk);
		check_reg(32'(o_out_valid), 32'd0, "out_valid after drain");
		for (int c = 0; c < NC; c++) begin
			check_reg(32'(model_q[c].size()), 32'd0, "words missing from egress");
		end
	endtask

	// Ingress and egress run side by side
	task automatic run_stream(input int n, input bit mixed, input bit random_ready);
		fork
			feed_words(n, mixed);
			repeat (n) expect_word(random_ready);
		join
		check_idle();
	endtask

	// Drains every queued word with ready held high
	task automatic drain_model();
		int total;
		total = 0;
		for (int c = 0; c < NC; c++) begin
			total += model_q[c].size();
			fill_cnt[c] = 0;
		end
		apb_write(buf_cfg_pkg::REG_CTRL, 32'd1);
		repeat (total) expect_word(1'b0);
		check_idle();
		apb_write(buf_cfg_pkg::REG_CTRL, 32'd0);
	endtask

	// Ingress with egress off, dropped words stay out of the model
	task automatic fill_class(input buf_data_pkg::class_e cls, input bit check_each);
		integer rnd;
		buf_data_pkg::word_t w;
		logic [31:0] rd;
		rnd = $random(seed);
		w.cls = cls;
		w.payload = rnd[7:0];
		if (fill_cnt[cls] < DEPTH) begin
			model_q[cls].push_back(w);
			fill_cnt[cls]++;
		end
		send_word(w);
		if (check_each) begin
			@(negedge clk);
			check_reg(32'(o_almost_full), 32'(afull_vector()), "almost_full flags");
			apb_read(buf_cfg_pkg::REG_FILL, rd);
			check_reg(rd, fill_word(), "FILL");
		end
	endtask

	task automatic test_reset_values();
		logic [31:0] rd;
		test_start = err_cnt;
		apb_read(buf_cfg_pkg::REG_CTRL, rd);
		check_reg(rd, 32'd0, "CTRL");
		apb_read(buf_cfg_pkg::REG_THRESH, rd);
		check_thresh(buf_cfg_pkg::thresh_t'(rd[15:0]), buf_cfg_pkg::THRESH_RESET, "THRESH");
		apb_read(buf_cfg_pkg::REG_STATUS, rd);
		check_reg(rd, 32'd0, "STATUS");
		apb_read(buf_cfg_pkg::REG_FILL, rd);
		check_reg(rd, 32'd0, "FILL");
		@(negedge clk);
		check_reg(32'(o_out_valid), 32'd0, "out_valid");
		finish_test("reset_values");
	endtask

	task automatic test_thresholds();
		logic [31:0] rd;
		buf_cfg_pkg::thresh_t th;
		test_start = err_cnt;
		th.almost_full = 8'd2;
		th.almost_empty = 8'd0;
		apb_write(buf_cfg_pkg::REG_THRESH, 32'(th));
		apb_read(buf_cfg_pkg::REG_THRESH, rd);
		check_thresh(buf_cfg_pkg::thresh_t'(rd[15:0]), th, "THRESH");
		cur_thresh = th;
		repeat (3) fill_class(buf_data_pkg::CLS_1, 1'b1);
		apb_write(buf_cfg_pkg::REG_THRESH, 32'(buf_cfg_pkg::THRESH_RESET));
		cur_thresh = buf_cfg_pkg::THRESH_RESET;
		drain_model();
		finish_test("thresholds");
	endtask

	// Single class with ready held high
	task automatic test_class_order();
		test_start = err_cnt;
		apb_write(buf_cfg_pkg::REG_CTRL, 32'd1);
		run_stream(12, 1'b0, 1'b0);
		finish_test("class_order");
	endtask

	// All classes with random ready gaps
	task automatic test_mixed_backpress();
		test_start = err_cnt;
		apb_write(buf_cfg_pkg::REG_CTRL, 32'd1);
		run_stream(24, 1'b1, 1'b1);
		@(posedge clk);
		i_out_ready <= 1'b1;
		apb_write(buf_cfg_pkg::REG_CTRL, 32'd0);
		finish_test("mixed_backpress");
	endtask

	task automatic test_overrun();
		logic [31:0] rd;
		test_start = err_cnt;
		repeat (DEPTH + 2) fill_class(buf_data_pkg::CLS_3, 1'b0);
		// Pulse then sticky bit, two edges after the last drop
		repeat (2) @(posedge clk);
		apb_read(buf_cfg_pkg::REG_STATUS, rd);
		check_reg(rd, 32'h8, "STATUS after overrun");
		apb_read(buf_cfg_pkg::REG_FILL, rd);
		check_reg(rd, fill_word(), "FILL at full");
		drain_model();
		apb_write(buf_cfg_pkg::REG_STATUS, 32'h8);
		apb_read(buf_cfg_pkg::REG_STATUS, rd);
		check_reg(rd, 32'd0, "STATUS after clear");
		finish_test("overrun");
	endtask

	initial begin
		seed = 32'h03319618;
		err_cnt = 0;
		chk_cnt = 0;
		test_start = 0;
		cur_thresh = buf_cfg_pkg::THRESH_RESET;
		for (int c = 0; c < NC; c++) begin
			fill_cnt[c] = 0;
		end
		reset_L = 1'b0;
		i_in_valid = 1'b0;
		i_in_word = '0;
		i_out_ready = 1'b1;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
		i_paddr = '0;
		i_pwdata = '0;
		repeat (8) @(posedge clk);
		reset_L <= 1'b1;
		test_reset_values();
		test_thresholds();
		test_class_order();
		test_mixed_backpress();
		test_overrun();
		$display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
src/buf_data_pkg.sv
src/buf_cfg_pkg.sv
src/flow_fifo.sv
src/class_steer.sv
src/egress_arbiter.sv
src/buf_apb_regs.sv
src/class_buffer_top.sv
sim/tb_class_buffer.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_class_buffer
RTL_TOP   ?= class_buffer_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

RTL_SRCS := $(filter src/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
